/* hdl/id_cfg.svh */
//////////////////////////////
// Sizing and address map of the RV32 decode stage
// The decoder and the LFSR assume a data width of 32
// Credit depth must fit the 3 bit credit counter
//////////////////////////////

`ifndef ID_CFG_SVH
`define ID_CFG_SVH

// Data and instruction width
`define ID_XLEN 32

// Architectural register count including x0
`define ID_NREGS 32

// Entries in the execute buffer and credits granted after reset
`define ID_CREDITS 4

// Control register port address width and register map
`define ID_CFG_AW 2
`define ID_CFG_CTRL 0
`define ID_CFG_PERIOD 1

// Start value of the dummy operand LFSR which must never be zero
`define ID_LFSR_SEED 32'h1D87_2B41

`endif

/* hdl/id_pkg.sv */
//////////////////////////////
// Types shared by the decode stage RTL and its testbench
// Unit bit positions are fixed by the UNIT_* constants
//////////////////////////////

`default_nettype none

`include "id_cfg.svh"

package id_pkg;

  // Data words and register indices
  typedef logic [`ID_XLEN-1:0] word_t;
  typedef logic [$clog2(`ID_NREGS)-1:0] reg_addr_t;

  // One enable per functional unit
  typedef logic [4:0] unit_vec_t;

  localparam unit_vec_t UNIT_ALU = 5'b00001;
  localparam unit_vec_t UNIT_MUL = 5'b00010;
  localparam unit_vec_t UNIT_LSU = 5'b00100;
  localparam unit_vec_t UNIT_CSR = 5'b01000;
  localparam unit_vec_t UNIT_SYS = 5'b10000;

  // Credit counter and dummy period
  typedef logic [2:0] credit_t;
  typedef logic [7:0] period_t;

  // Operation handed to execute
  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_MUL,
    OP_LOAD,
    OP_STORE,
    OP_CSRRW,
    OP_ECALL,
    OP_EBREAK,
    OP_MRET,
    OP_WFI,
    OP_NONE
  } op_e;

  // Source of operand b
  typedef enum logic [1:0] {
    OPB_REG,
    OPB_IMM,
    OPB_NONE
  } opb_sel_e;

endpackage

`default_nettype wire

/* hdl/id_dec_if.sv */
//////////////////////////////
// Decoded instruction from decoder to issue block
// Purely combinational and follows the held instruction
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

interface id_dec_if;

  id_pkg::unit_vec_t units;
  id_pkg::op_e       op;
  id_pkg::opb_sel_e  opb_sel;
  id_pkg::reg_addr_t rs1;
  id_pkg::reg_addr_t rs2;
  logic              rs1_re;
  logic              rs2_re;
  id_pkg::reg_addr_t rd;
  logic              rf_we;
  id_pkg::word_t     imm;
  logic              illegal;

  // Decoder side
  modport dec (
    output units, op, opb_sel, rs1, rs2, rs1_re, rs2_re, rd, rf_we, imm, illegal
  );

  // Issue side
  modport iss (
    input units, op, opb_sel, rs1, rs2, rs1_re, rs2_re, rd, rf_we, imm, illegal
  );

endinterface

`default_nettype wire

/* hdl/id_decoder.sv */
//////////////////////////////
// RV32 subset decoder for OP, ADDI, LOAD, STORE, CSRRW and SYSTEM
// Anything else is flagged illegal with no unit and no write
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "id_cfg.svh"

module id_decoder (
  input  id_pkg::word_t instr_i,
  id_dec_if.dec         dec
);

  logic [6:0]    opcode;
  logic [2:0]    funct3;
  logic [6:0]    funct7;
  id_pkg::word_t imm_i_type;
  id_pkg::word_t imm_s_type;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Sign extended immediates for I and S formats
  assign imm_i_type = {{(`ID_XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{(`ID_XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};

  // Register fields sit at fixed positions in every format
  assign dec.rs1 = instr_i[19:15];
  assign dec.rs2 = instr_i[24:20];
  assign dec.rd  = instr_i[11:7];

  always_comb begin
    dec.units   = '0;
    dec.op      = id_pkg::OP_NONE;
    dec.opb_sel = id_pkg::OPB_NONE;
    dec.rs1_re  = 1'b0;
    dec.rs2_re  = 1'b0;
    dec.rf_we   = 1'b0;
    dec.imm     = '0;
    dec.illegal = 1'b0;

    case (opcode)
      // Register to register ALU and MUL
      7'b0110011: begin
        dec.units   = id_pkg::UNIT_ALU;
        dec.opb_sel = id_pkg::OPB_REG;
        dec.rs1_re  = 1'b1;
        dec.rs2_re  = 1'b1;
        dec.rf_we   = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: dec.op = id_pkg::OP_ADD;
          {7'h20, 3'b000}: dec.op = id_pkg::OP_SUB;
          {7'h00, 3'b111}: dec.op = id_pkg::OP_AND;
          {7'h00, 3'b110}: dec.op = id_pkg::OP_OR;
          {7'h00, 3'b100}: dec.op = id_pkg::OP_XOR;
          {7'h01, 3'b000}: begin
            dec.op    = id_pkg::OP_MUL;
            dec.units = id_pkg::UNIT_MUL;
          end
          default: dec.illegal = 1'b1;
        endcase
      end
      // Only ADDI from the OP-IMM group
      7'b0010011: begin
        dec.units   = id_pkg::UNIT_ALU;
        dec.op      = id_pkg::OP_ADD;
        dec.opb_sel = id_pkg::OPB_IMM;
        dec.rs1_re  = 1'b1;
        dec.rf_we   = 1'b1;
        dec.imm     = imm_i_type;
        dec.illegal = (funct3 != 3'b000);
      end
      // Loads of byte, half and word, signed or not
      7'b0000011: begin
        dec.units   = id_pkg::UNIT_LSU;
        dec.op      = id_pkg::OP_LOAD;
        dec.opb_sel = id_pkg::OPB_IMM;
        dec.rs1_re  = 1'b1;
        dec.rf_we   = 1'b1;
        dec.imm     = imm_i_type;
        dec.illegal = (funct3 == 3'b011) || funct3[2] && funct3[1];
      end
      // Stores carry the offset as operand b and still read rs2
      7'b0100011: begin
        dec.units   = id_pkg::UNIT_LSU;
        dec.op      = id_pkg::OP_STORE;
        dec.opb_sel = id_pkg::OPB_IMM;
        dec.rs1_re  = 1'b1;
        dec.rs2_re  = 1'b1;
        dec.imm     = imm_s_type;
        dec.illegal = (funct3[2] || funct3 == 3'b011);
      end
      7'b1110011: begin
        if (funct3 == 3'b001) begin
          // CSRRW passes the CSR address as the immediate
          dec.units   = id_pkg::UNIT_CSR;
          dec.op      = id_pkg::OP_CSRRW;
          dec.opb_sel = id_pkg::OPB_IMM;
          dec.rs1_re  = 1'b1;
          dec.rf_we   = 1'b1;
          dec.imm     = imm_i_type;
        end else begin
          // SYSTEM encodings are matched on the whole word
          dec.units = id_pkg::UNIT_SYS;
          case (instr_i)
            32'h0000_0073: dec.op = id_pkg::OP_ECALL;
            32'h0010_0073: dec.op = id_pkg::OP_EBREAK;
            32'h3020_0073: dec.op = id_pkg::OP_MRET;
            32'h1050_0073: dec.op = id_pkg::OP_WFI;
            default:       dec.illegal = 1'b1;
          endcase
        end
      end
      default: dec.illegal = 1'b1;
    endcase

    // An illegal encoding must not reach any unit or the register file
    if (dec.illegal) begin
      dec.units   = '0;
      dec.op      = id_pkg::OP_NONE;
      dec.opb_sel = id_pkg::OPB_NONE;
      dec.rs1_re  = 1'b0;
      dec.rs2_re  = 1'b0;
      dec.rf_we   = 1'b0;
      dec.imm     = '0;
    end
  end

endmodule

`default_nettype wire

/* hdl/id_regfile.sv */
//////////////////////////////
// Two read ports and one write port
// x0 reads zero and ignores writes
// A write in the same cycle is bypassed to the readers
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "id_cfg.svh"

module id_regfile (
  input  logic              clk,
  input  logic              rst_i,
  input  id_pkg::reg_addr_t raddr_a_i,
  input  id_pkg::reg_addr_t raddr_b_i,
  output id_pkg::word_t     rdata_a_o,
  output id_pkg::word_t     rdata_b_o,
  input  logic              we_i,
  input  id_pkg::reg_addr_t waddr_i,
  input  id_pkg::word_t     wdata_i
);

  // No storage exists for x0
  id_pkg::word_t regs_q [1:`ID_NREGS-1];

  // Bypassed read of one port
  function automatic id_pkg::word_t read_port(input id_pkg::reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end else if (we_i && (waddr_i == addr)) begin
      return wdata_i;
    end
    return regs_q[addr];
  endfunction

  always_comb begin
    rdata_a_o = read_port(raddr_a_i);
    rdata_b_o = read_port(raddr_b_i);
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 1; i < `ID_NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

/* hdl/id_ctrl_regs.sv */
//////////////////////////////
// Halt, dummy enable and dummy period
// Writes to unmapped addresses are dropped
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "id_cfg.svh"

module id_ctrl_regs (
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  cfg_we_i,
  input  logic [`ID_CFG_AW-1:0] cfg_addr_i,
  input  id_pkg::word_t         cfg_wdata_i,
  output logic                  halt_o,
  output logic                  dummy_en_o,
  output id_pkg::period_t       period_o
);

  logic ctrl_sel;
  logic period_sel;

  // Address decode of the two mapped registers
  assign ctrl_sel   = cfg_we_i && (cfg_addr_i == `ID_CFG_AW'(`ID_CFG_CTRL));
  assign period_sel = cfg_we_i && (cfg_addr_i == `ID_CFG_AW'(`ID_CFG_PERIOD));

  //////////////////////////////
  // CTRL register
  //////////////////////////////

  // Bit 0 freezes the stage and bit 1 enables dummy insertion
  always_ff @(posedge clk) begin
    if (rst_i) begin
      halt_o     <= 1'b0;
      dummy_en_o <= 1'b0;
    end else if (ctrl_sel) begin
      halt_o     <= cfg_wdata_i[0];
      dummy_en_o <= cfg_wdata_i[1];
    end
  end

  //////////////////////////////
  // PERIOD register
  //////////////////////////////

  // Zero is kept as written and treated as one by the issue block
  always_ff @(posedge clk) begin
    if (rst_i) begin
      period_o <= id_pkg::period_t'(1);
    end else if (period_sel) begin
      period_o <= cfg_wdata_i[$bits(id_pkg::period_t)-1:0];
    end
  end

endmodule

`default_nettype wire

/* hdl/id_issue.sv */
//////////////////////////////
// One entry holding register, credit counter and ID/EX register
// Dummies are only inserted ahead of a waiting real instruction
// Execute must never return more credits than it received
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "id_cfg.svh"

module id_issue (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              instr_valid_i,
  input  id_pkg::word_t     instr_i,
  output logic              id_ready_o,
  input  logic              kill_i,
  input  logic              halt_i,
  input  logic              dummy_en_i,
  input  id_pkg::period_t   period_i,
  output id_pkg::word_t     held_instr_o,
  id_dec_if.iss             dec,
  output id_pkg::reg_addr_t raddr_a_o,
  output id_pkg::reg_addr_t raddr_b_o,
  input  id_pkg::word_t     rdata_a_i,
  input  id_pkg::word_t     rdata_b_i,
  input  logic              ex_credit_i,
  output logic              ex_valid_o,
  output logic              ex_dummy_o,
  output id_pkg::unit_vec_t ex_units_o,
  output id_pkg::op_e       ex_op_o,
  output id_pkg::word_t     ex_operand_a_o,
  output id_pkg::word_t     ex_operand_b_o,
  output id_pkg::reg_addr_t ex_rd_o,
  output logic              ex_rf_we_o,
  output logic              ex_illegal_o
);

  // Galois taps for x^32 + x^22 + x^2 + x + 1
  localparam id_pkg::word_t LFSR_TAPS = 32'h8020_0003;

  logic            hold_valid_q;
  id_pkg::word_t   hold_instr_q;
  id_pkg::credit_t credit_q;
  id_pkg::period_t real_cnt_q;
  id_pkg::period_t period_eff;
  id_pkg::word_t   lfsr_q;
  id_pkg::word_t   lfsr_nxt;
  id_pkg::word_t   opa_real;
  id_pkg::word_t   opb_real;
  logic            accept;
  logic            slot;
  logic            dummy_due;
  logic            issue_real;
  logic            issue_dummy;

  //////////////////////////////
  // Issue decision
  //////////////////////////////

  assign period_eff = (period_i == '0) ? id_pkg::period_t'(1) : period_i;
  assign dummy_due  = dummy_en_i && (real_cnt_q >= period_eff);

  // An issue slot needs a held instruction, a credit and no halt or kill
  assign slot        = hold_valid_q && (credit_q != '0) && !halt_i && !kill_i;
  assign issue_dummy = slot && dummy_due;
  assign issue_real  = slot && !dummy_due;

  // Kill always lets fetch proceed so the flushed slot can refill
  assign id_ready_o = kill_i || (!halt_i && (!hold_valid_q || issue_real));
  assign accept     = instr_valid_i && id_ready_o;

  // Register addresses of the held instruction go to the register file
  assign held_instr_o = hold_instr_q;
  assign raddr_a_o    = dec.rs1;
  assign raddr_b_o    = dec.rs2;

  // Operands of a real instruction with unread sources forced to zero
  assign opa_real = dec.rs1_re ? rdata_a_i : '0;
  always_comb begin
    case (dec.opb_sel)
      id_pkg::OPB_REG: opb_real = dec.rs2_re ? rdata_b_i : '0;
      id_pkg::OPB_IMM: opb_real = dec.imm;
      default:         opb_real = '0;
    endcase
  end

  assign lfsr_nxt = {1'b0, lfsr_q[`ID_XLEN-1:1]} ^ ({`ID_XLEN{lfsr_q[0]}} & LFSR_TAPS);

  //////////////////////////////
  // Control state
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      hold_valid_q <= 1'b0;
      credit_q     <= id_pkg::credit_t'(`ID_CREDITS);
      real_cnt_q   <= '0;
      lfsr_q       <= `ID_LFSR_SEED;
      ex_valid_o   <= 1'b0;
      ex_dummy_o   <= 1'b0;
      ex_units_o   <= '0;
      ex_rf_we_o   <= 1'b0;
      ex_illegal_o <= 1'b0;
    end else begin
      // A new instruction wins over the flush of the previous one
      if (accept) begin
        hold_valid_q <= 1'b1;
      end else if (kill_i || issue_real) begin
        hold_valid_q <= 1'b0;
      end

      credit_q <= credit_q - id_pkg::credit_t'(slot) + id_pkg::credit_t'(ex_credit_i);

      // Real issues since the last dummy saturate at the period
      if (!dummy_en_i || issue_dummy) begin
        real_cnt_q <= '0;
      end else if (issue_real && (real_cnt_q < period_eff)) begin
        real_cnt_q <= real_cnt_q + 1'b1;
      end

      if (issue_dummy) begin
        lfsr_q <= lfsr_nxt;
      end

      ex_valid_o <= slot;
      ex_dummy_o <= issue_dummy;
      if (issue_real) begin
        ex_units_o   <= dec.units;
        ex_rf_we_o   <= dec.rf_we;
        ex_illegal_o <= dec.illegal;
      end else if (issue_dummy) begin
        ex_units_o   <= id_pkg::UNIT_ALU;
        ex_rf_we_o   <= 1'b0;
        ex_illegal_o <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // Payload
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (accept) begin
      hold_instr_q <= instr_i;
    end
    if (issue_real) begin
      ex_op_o        <= dec.op;
      ex_operand_a_o <= opa_real;
      ex_operand_b_o <= opb_real;
      ex_rd_o        <= dec.rd;
    end else if (issue_dummy) begin
      // Dummy is an ADD of two LFSR words into x0
      ex_op_o        <= id_pkg::OP_ADD;
      ex_operand_a_o <= lfsr_q;
      ex_operand_b_o <= lfsr_nxt;
      ex_rd_o        <= '0;
    end
  end

endmodule

`default_nettype wire

/* hdl/id_stage_top.sv */
//////////////////////////////
// Decode stage top with plain ports
// No forwarding beyond the same cycle register write
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "id_cfg.svh"

module id_stage_top (
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  instr_valid_i,
  input  id_pkg::word_t         instr_i,
  output logic                  id_ready_o,
  input  logic                  kill_i,
  input  logic                  cfg_we_i,
  input  logic [`ID_CFG_AW-1:0] cfg_addr_i,
  input  id_pkg::word_t         cfg_wdata_i,
  input  logic                  wb_we_i,
  input  id_pkg::reg_addr_t     wb_addr_i,
  input  id_pkg::word_t         wb_data_i,
  input  logic                  ex_credit_i,
  output logic                  ex_valid_o,
  output logic                  ex_dummy_o,
  output id_pkg::unit_vec_t     ex_units_o,
  output id_pkg::op_e           ex_op_o,
  output id_pkg::word_t         ex_operand_a_o,
  output id_pkg::word_t         ex_operand_b_o,
  output id_pkg::reg_addr_t     ex_rd_o,
  output logic                  ex_rf_we_o,
  output logic                  ex_illegal_o
);

  logic              halt;
  logic              dummy_en;
  id_pkg::period_t   period;
  id_pkg::word_t     held_instr;
  id_pkg::reg_addr_t raddr_a;
  id_pkg::reg_addr_t raddr_b;
  id_pkg::word_t     rdata_a;
  id_pkg::word_t     rdata_b;

  // Decoded fields of the held instruction
  id_dec_if dec_if ();

  id_ctrl_regs u_ctrl_regs (
    .clk         (clk),
    .rst_i       (rst_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .halt_o      (halt),
    .dummy_en_o  (dummy_en),
    .period_o    (period)
  );

  id_regfile u_regfile (
    .clk       (clk),
    .rst_i     (rst_i),
    .raddr_a_i (raddr_a),
    .raddr_b_i (raddr_b),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .we_i      (wb_we_i),
    .waddr_i   (wb_addr_i),
    .wdata_i   (wb_data_i)
  );

  id_decoder u_decoder (
    .instr_i (held_instr),
    .dec     (dec_if.dec)
  );

  id_issue u_issue (
    .clk            (clk),
    .rst_i          (rst_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .id_ready_o     (id_ready_o),
    .kill_i         (kill_i),
    .halt_i         (halt),
    .dummy_en_i     (dummy_en),
    .period_i       (period),
    .held_instr_o   (held_instr),
    .dec            (dec_if.iss),
    .raddr_a_o      (raddr_a),
    .raddr_b_o      (raddr_b),
    .rdata_a_i      (rdata_a),
    .rdata_b_i      (rdata_b),
    .ex_credit_i    (ex_credit_i),
    .ex_valid_o     (ex_valid_o),
    .ex_dummy_o     (ex_dummy_o),
    .ex_units_o     (ex_units_o),
    .ex_op_o        (ex_op_o),
    .ex_operand_a_o (ex_operand_a_o),
    .ex_operand_b_o (ex_operand_b_o),
    .ex_rd_o        (ex_rd_o),
    .ex_rf_we_o     (ex_rf_we_o),
    .ex_illegal_o   (ex_illegal_o)
  );

endmodule

`default_nettype wire

/* bench/id_stage_sva.sv */
//////////////////////////////
// Control checks bound into the decode stage top
// halt_i is the halt bit held in the control registers
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module id_stage_sva (
  input logic              clk,
  input logic              rst_i,
  input logic              halt_i,
  input logic              kill_i,
  input logic              id_ready_o,
  input logic              ex_valid_o,
  input logic              ex_illegal_o,
  input logic              ex_rf_we_o,
  input id_pkg::unit_vec_t ex_units_o
);

  int sva_errors = 0;

  // At most one functional unit is ever enabled
  a_units_onehot0 : assert property (@(posedge clk) disable iff (rst_i)
    $onehot0(ex_units_o))
    else begin
      $error("more than one unit enabled");
      sva_errors++;
    end

  // An illegal issue reaches no unit and writes no register
  a_illegal_quiet : assert property (@(posedge clk) disable iff (rst_i)
    ex_valid_o && ex_illegal_o |-> (ex_units_o == '0) && !ex_rf_we_o)
    else begin
      $error("illegal issue with unit or write enable");
      sva_errors++;
    end

  // Halt blocks fetch, and the issue slot from the next cycle on
  a_halt_ready : assert property (@(posedge clk) disable iff (rst_i)
    halt_i && !kill_i |-> !id_ready_o)
    else begin
      $error("ready while halted");
      sva_errors++;
    end

  a_halt_issue : assert property (@(posedge clk) disable iff (rst_i)
    halt_i |=> !ex_valid_o)
    else begin
      $error("issue while halted");
      sva_errors++;
    end

  // Kill frees the stage and suppresses the issue on that edge
  a_kill : assert property (@(posedge clk) disable iff (rst_i)
    kill_i |-> id_ready_o ##1 !ex_valid_o)
    else begin
      $error("kill did not flush the held instruction");
      sva_errors++;
    end

endmodule

bind id_stage_top id_stage_sva u_sva (
  .clk          (clk),
  .rst_i        (rst_i),
  .halt_i       (halt),
  .kill_i       (kill_i),
  .id_ready_o   (id_ready_o),
  .ex_valid_o   (ex_valid_o),
  .ex_illegal_o (ex_illegal_o),
  .ex_rf_we_o   (ex_rf_we_o),
  .ex_units_o   (ex_units_o)
);

`default_nettype wire

/* bench/id_stage_tb.sv */
//////////////////////////////
// Testbench of the decode stage with a register model
// Register writes other than to x0 happen only while the stage is drained
// Expected fields are worked out when an instruction is built
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "id_cfg.svh"

module id_stage_tb;

  // Enough for every phase even with slow random credit return
  localparam int MAX_CYCLES = 20000;

  logic                  clk;
  logic                  rst_i;
  logic                  instr_valid_i;
  id_pkg::word_t         instr_i;
  logic                  id_ready_o;
  logic                  kill_i;
  logic                  cfg_we_i;
  logic [`ID_CFG_AW-1:0] cfg_addr_i;
  id_pkg::word_t         cfg_wdata_i;
  logic                  wb_we_i;
  id_pkg::reg_addr_t     wb_addr_i;
  id_pkg::word_t         wb_data_i;
  logic                  ex_credit_i;
  logic                  ex_valid_o;
  logic                  ex_dummy_o;
  id_pkg::unit_vec_t     ex_units_o;
  id_pkg::op_e           ex_op_o;
  id_pkg::word_t         ex_operand_a_o;
  id_pkg::word_t         ex_operand_b_o;
  id_pkg::reg_addr_t     ex_rd_o;
  logic                  ex_rf_we_o;
  logic                  ex_illegal_o;

  // Register model and FIFO of expected real items
  id_pkg::word_t     model_regs [0:`ID_NREGS-1];
  id_pkg::word_t     q_instr [$];
  id_pkg::unit_vec_t q_units [$];
  id_pkg::op_e       q_op [$];
  id_pkg::word_t     q_a [$];
  id_pkg::word_t     q_b [$];
  id_pkg::reg_addr_t q_rd [$];
  logic              q_we [$];
  logic              q_ill [$];

  // Fields of the instruction built last
  id_pkg::word_t     e_instr;
  id_pkg::unit_vec_t e_units;
  id_pkg::op_e       e_op;
  id_pkg::word_t     e_a;
  id_pkg::word_t     e_b;
  id_pkg::reg_addr_t e_rd;
  logic              e_we;
  logic              e_ill;

  int   issued = 0;
  int   returned = 0;
  int   cycles = 0;
  int   real_since = 0;
  int   dummies = 0;
  int   dummy_period = 1;
  logic dummy_on = 1'b0;
  logic withhold = 1'b0;

  id_stage_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic fail_now(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("=== FAIL ===");
      $fatal(1);
    end
  end

  // A bound assertion failure ends the run at once
  always @(negedge clk) begin
    if (DUT.u_sva.sva_errors != 0) begin
      $display("A bound assertion on the stage control failed");
      $display("=== FAIL ===");
      $fatal(1);
    end
  end

  //////////////////////////////
  // Credit return and output monitor
  //////////////////////////////

  always @(negedge clk) begin
    ex_credit_i = 1'b0;
    if (!rst_i && !withhold && (issued > returned) && ($urandom % 3 == 0)) begin
      ex_credit_i = 1'b1;
      returned++;
    end
  end

  always @(posedge clk) begin
    if (!rst_i && ex_valid_o) begin
      issued++;
      assert (issued - returned <= `ID_CREDITS)
        else fail_now("more items in flight than credits");
      if (ex_dummy_o) begin
        assert (dummy_on && (real_since == ((dummy_period == 0) ? 1 : dummy_period)))
          else fail_now("dummy at the wrong point of the stream");
        assert (ex_units_o == id_pkg::UNIT_ALU && ex_op_o == id_pkg::OP_ADD)
          else fail_now("dummy is not an ALU add");
        assert (ex_rd_o == '0 && !ex_rf_we_o && !ex_illegal_o)
          else fail_now("dummy writes a register");
        dummies++;
        real_since = 0;
      end else begin
        assert (!(dummy_on && real_since >= ((dummy_period == 0) ? 1 : dummy_period)))
          else fail_now("dummy missing after the period");
        assert (q_instr.size() > 0) else fail_now("unexpected real item");
        assert (ex_units_o == q_units[0]) else fail_now("unit enable mismatch");
        assert (ex_op_o == q_op[0]) else fail_now("operation mismatch");
        assert (ex_operand_a_o == q_a[0]) else fail_now("operand a mismatch");
        assert (ex_operand_b_o == q_b[0]) else fail_now("operand b mismatch");
        assert (ex_rd_o == q_rd[0]) else fail_now("rd mismatch");
        assert (ex_rf_we_o == q_we[0]) else fail_now("rf_we mismatch");
        assert (ex_illegal_o == q_ill[0]) else fail_now("illegal flag mismatch");
        void'(q_instr.pop_front());
        void'(q_units.pop_front());
        void'(q_op.pop_front());
        void'(q_a.pop_front());
        void'(q_b.pop_front());
        void'(q_rd.pop_front());
        void'(q_we.pop_front());
        void'(q_ill.pop_front());
        real_since++;
      end
    end
  end

  //////////////////////////////
  // Instruction builder
  //////////////////////////////

  // Kinds 0..5 are R-type, then addi, load, store, csrrw, system, illegal
  task automatic build(input int kind, input id_pkg::reg_addr_t rs1,
                       input id_pkg::reg_addr_t rs2);
    logic [11:0]       imm;
    logic [2:0]        f3;
    logic [6:0]        f7;
    logic [6:0]        opc;
    id_pkg::reg_addr_t rd;
    int                pick;
    imm   = 12'($urandom);
    rd    = id_pkg::reg_addr_t'($urandom);
    e_a   = model_regs[rs1];
    e_b   = {{20{imm[11]}}, imm};
    e_we  = 1'b1;
    e_ill = 1'b0;
    e_rd  = rd;
    case (kind)
      0, 1, 2, 3, 4, 5: begin
        f7 = (kind == 1) ? 7'h20 : ((kind == 5) ? 7'h01 : 7'h00);
        f3 = (kind == 2) ? 3'b111 : (kind == 3) ? 3'b110 : (kind == 4) ? 3'b100 : 3'b000;
        e_instr = {f7, rs2, rs1, f3, rd, 7'h33};
        e_units = (kind == 5) ? id_pkg::UNIT_MUL : id_pkg::UNIT_ALU;
        e_op    = (kind == 0) ? id_pkg::OP_ADD : (kind == 1) ? id_pkg::OP_SUB :
                  (kind == 2) ? id_pkg::OP_AND : (kind == 3) ? id_pkg::OP_OR :
                  (kind == 4) ? id_pkg::OP_XOR : id_pkg::OP_MUL;
        e_b     = model_regs[rs2];
      end
      6: begin
        e_instr = {imm, rs1, 3'b000, rd, 7'h13};
        e_units = id_pkg::UNIT_ALU;
        e_op    = id_pkg::OP_ADD;
      end
      7: begin
        pick    = $urandom % 5;
        f3      = (pick == 3) ? 3'b100 : (pick == 4) ? 3'b101 : 3'(pick);
        e_instr = {imm, rs1, f3, rd, 7'h03};
        e_units = id_pkg::UNIT_LSU;
        e_op    = id_pkg::OP_LOAD;
      end
      8: begin
        f3      = 3'($urandom % 3);
        e_instr = {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
        e_units = id_pkg::UNIT_LSU;
        e_op    = id_pkg::OP_STORE;
        e_rd    = imm[4:0];
        e_we    = 1'b0;
      end
      9: begin
        e_instr = {imm, rs1, 3'b001, rd, 7'h73};
        e_units = id_pkg::UNIT_CSR;
        e_op    = id_pkg::OP_CSRRW;
      end
      10: begin
        pick    = $urandom % 4;
        e_instr = (pick == 0) ? 32'h0000_0073 : (pick == 1) ? 32'h0010_0073 :
                  (pick == 2) ? 32'h3020_0073 : 32'h1050_0073;
        e_op    = (pick == 0) ? id_pkg::OP_ECALL : (pick == 1) ? id_pkg::OP_EBREAK :
                  (pick == 2) ? id_pkg::OP_MRET : id_pkg::OP_WFI;
        e_units = id_pkg::UNIT_SYS;
        e_a     = '0;
        e_b     = '0;
        e_rd    = '0;
        e_we    = 1'b0;
      end
      default: begin
        // Any opcode outside the five decoded groups is reserved here
        opc = 7'($urandom);
        while (opc == 7'h03 || opc == 7'h13 || opc == 7'h23 || opc == 7'h33 ||
               opc == 7'h73) begin
          opc = 7'($urandom);
        end
        e_instr = {25'($urandom), opc};
        e_units = '0;
        e_op    = id_pkg::OP_NONE;
        e_a     = '0;
        e_b     = '0;
        e_rd    = e_instr[11:7];
        e_we    = 1'b0;
        e_ill   = 1'b1;
      end
    endcase
  endtask

  //////////////////////////////
  // Driver tasks
  //////////////////////////////

  task automatic drive_instr();
    @(negedge clk);
    instr_valid_i = 1'b1;
    instr_i       = e_instr;
  endtask

  // Waits for the accepting edge and records the expected item
  task automatic wait_accept();
    logic acc;
    acc = 1'b0;
    while (!acc) begin
      @(posedge clk);
      acc = id_ready_o;
    end
    q_instr.push_back(e_instr);
    q_units.push_back(e_units);
    q_op.push_back(e_op);
    q_a.push_back(e_a);
    q_b.push_back(e_b);
    q_rd.push_back(e_rd);
    q_we.push_back(e_we);
    q_ill.push_back(e_ill);
  endtask

  task automatic send_random(input int kind);
    build(kind, id_pkg::reg_addr_t'($urandom), id_pkg::reg_addr_t'($urandom));
    drive_instr();
    wait_accept();
  endtask

  task automatic go_idle();
    @(negedge clk);
    instr_valid_i = 1'b0;
  endtask

  task automatic drain();
    go_idle();
    while (q_instr.size() > 0 || issued != returned) begin
      @(negedge clk);
    end
  endtask

  task automatic write_reg(input id_pkg::reg_addr_t addr, input id_pkg::word_t data);
    @(negedge clk);
    wb_we_i   = 1'b1;
    wb_addr_i = addr;
    wb_data_i = data;
    @(negedge clk);
    wb_we_i = 1'b0;
    if (addr != '0) begin
      model_regs[addr] = data;
    end
  endtask

  task automatic write_cfg(input int addr, input id_pkg::word_t data);
    @(negedge clk);
    cfg_we_i    = 1'b1;
    cfg_addr_i  = `ID_CFG_AW'(addr);
    cfg_wdata_i = data;
    @(negedge clk);
    cfg_we_i = 1'b0;
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    void'($urandom(87));
    rst_i         = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    kill_i        = 1'b0;
    cfg_we_i      = 1'b0;
    cfg_addr_i    = '0;
    cfg_wdata_i   = '0;
    wb_we_i       = 1'b0;
    wb_addr_i     = '0;
    wb_data_i     = '0;
    ex_credit_i   = 1'b0;
    for (int i = 0; i < `ID_NREGS; i++) begin
      model_regs[i] = '0;
    end
    repeat (8) @(negedge clk);
    rst_i = 1'b0;

    for (int i = 0; i < `ID_NREGS; i++) begin
      write_reg(id_pkg::reg_addr_t'(i), $urandom);
    end

    // Legal and illegal mix in input order
    for (int i = 0; i < 150; i++) begin
      send_random($urandom % 12);
    end
    drain();

    // x0 as a source right after and during a write to x0
    write_reg('0, 32'hDEAD_BEEF);
    build(0, '0, '0);
    drive_instr();
    wait_accept();
    // The held add reads x0 in the same cycle as this write
    @(negedge clk);
    instr_valid_i = 1'b0;
    wb_we_i       = 1'b1;
    wb_addr_i     = '0;
    wb_data_i     = 32'h1234_5678;
    @(negedge clk);
    wb_we_i = 1'b0;
    build(6, '0, 5'd3);
    drive_instr();
    wait_accept();
    drain();

    // With free credit the item shows one cycle after acceptance
    send_random(0);
    go_idle();
    @(posedge clk);
    assert (!ex_valid_o) else fail_now("item issued too early");
    @(posedge clk);
    assert (ex_valid_o) else fail_now("item not issued one cycle after accept");
    drain();

    // Use up all credits, then kill the held instruction
    withhold = 1'b1;
    for (int i = 0; i < `ID_CREDITS + 1; i++) begin
      send_random($urandom % 11);
    end
    go_idle();
    repeat (2) @(posedge clk);
    repeat (6) begin
      @(posedge clk);
      assert (!id_ready_o && !ex_valid_o)
        else fail_now("stage not stalled without credit");
    end
    @(negedge clk);
    kill_i = 1'b1;
    @(negedge clk);
    kill_i = 1'b0;
    void'(q_instr.pop_back());
    void'(q_units.pop_back());
    void'(q_op.pop_back());
    void'(q_a.pop_back());
    void'(q_b.pop_back());
    void'(q_rd.pop_back());
    void'(q_we.pop_back());
    void'(q_ill.pop_back());
    withhold = 1'b0;
    drain();

    // Halt set on the accepting edge keeps the instruction held until cleared
    build(9, id_pkg::reg_addr_t'($urandom), '0);
    drive_instr();
    cfg_we_i    = 1'b1;
    cfg_addr_i  = `ID_CFG_AW'(`ID_CFG_CTRL);
    cfg_wdata_i = 32'h1;
    wait_accept();
    go_idle();
    cfg_we_i = 1'b0;
    repeat (10) begin
      @(posedge clk);
      assert (!id_ready_o && !ex_valid_o) else fail_now("stage active while halted");
    end
    write_cfg(`ID_CFG_CTRL, 32'h0);
    drain();

    // Dummy insertion with period zero and then three
    for (int p = 0; p < 4; p += 3) begin
      write_cfg(`ID_CFG_PERIOD, p);
      write_cfg(`ID_CFG_CTRL, 32'h2);
      dummy_period = p;
      dummy_on     = 1'b1;
      real_since   = 0;
      dummies      = 0;
      for (int i = 0; i < 30; i++) begin
        send_random($urandom % 12);
      end
      drain();
      assert (dummies > 0) else fail_now("no dummy issued while enabled");
      write_cfg(`ID_CFG_CTRL, 32'h0);
      dummy_on = 1'b0;
    end

    repeat (4) @(negedge clk);
    if (DUT.u_sva.sva_errors != 0) begin
      $display("A bound assertion on the stage control failed");
      $display("=== FAIL ===");
      $fatal(1);
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+hdl
hdl/id_pkg.sv
hdl/id_dec_if.sv
hdl/id_decoder.sv
hdl/id_regfile.sv
hdl/id_ctrl_regs.sv
hdl/id_issue.sv
hdl/id_stage_top.sv
bench/id_stage_sva.sv
bench/id_stage_tb.sv
